//--- design/l2_cache.sv
`include "l2_cache_params.svh"

module l2_cache (
	input logic clk,
	input logic rst,
	input l2_cache_pkg::l2_req_t req,
	output l2_cache_pkg::l2_line_t mem_rdata,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output l2_cache_pkg::l2_addr_t pmem_address,
	output l2_cache_pkg::l2_line_t pmem_wdata,
	input l2_cache_pkg::l2_line_t pmem_rdata,
	input logic pmem_resp
);
	import l2_cache_pkg::*;

	l2_tag_t req_tag;
	l2_index_t req_index;
	l2_ctrl_t ctrl;
	logic hit;
	way_t hit_way;
	way_t victim;
	way_t rd_way;
	way_mask_t dirty;
	l2_tag_t way_tags [4];
	l2_line_t array_wdata;
	l2_line_t array_rdata;

	assign req_tag = req.addr[`L2_ADDR_BITS-1 -: `L2_TAG_BITS];
	assign req_index = req.addr[`L2_INDEX_BITS-1:0];

	assign array_wdata = ctrl.fill_sel ? pmem_rdata : req.wdata;

	// Write-back goes to the victim's own line address
	assign pmem_address = ctrl.wb_sel ? {way_tags[victim], req_index} : req.addr;
	assign pmem_wdata = array_rdata;
	assign mem_rdata = array_rdata;

	l2_cache_control control_i (
		.clk(clk), .rst(rst),
		.read(req.read), .write(req.write),
		.hit(hit), .hit_way(hit_way), .victim(victim), .dirty(dirty),
		.pmem_resp(pmem_resp), .ctrl(ctrl), .rd_way(rd_way),
		.pmem_read(pmem_read), .pmem_write(pmem_write), .mem_resp(mem_resp)
	);

	l2_way_meta meta_i (
		.clk(clk), .rst(rst), .index(req_index), .tag(req_tag), .ctrl(ctrl),
		.hit(hit), .hit_way(hit_way), .dirty(dirty), .way_tags(way_tags)
	);

	l2_data_array data_i (
		.clk(clk), .rst(rst), .index(req_index), .ld_way(ctrl.ld_way),
		.wdata(array_wdata), .rd_way(rd_way), .rdata(array_rdata)
	);

	l2_plru plru_i (
		.clk(clk), .rst(rst), .index(req_index), .ld_lru(ctrl.ld_lru),
		.access_way(rd_way), .victim(victim)
	);

endmodule : l2_cache

//--- design/l2_cache_control.sv
module l2_cache_control (
	input logic clk,
	input logic rst,
	input logic read,
	input logic write,
	input logic hit,
	input l2_cache_pkg::way_t hit_way,
	input l2_cache_pkg::way_t victim,
	input l2_cache_pkg::way_mask_t dirty,
	input logic pmem_resp,
	output l2_cache_pkg::l2_ctrl_t ctrl,
	output l2_cache_pkg::way_t rd_way,
	output logic pmem_read,
	output logic pmem_write,
	output logic mem_resp
);
	import l2_cache_pkg::*;

	l2_state_e state;
	l2_state_e state_next;

	way_mask_t hit_mask;
	way_mask_t victim_mask;
	logic victim_dirty;

	assign hit_mask = way_mask_t'(4'b0001 << hit_way);
	assign victim_mask = way_mask_t'(4'b0001 << victim);
	assign victim_dirty = |(dirty & victim_mask);

	// Data array read port follows the way being served
	always_comb begin
		if (state == st_idle || state == st_resp)
			rd_way = hit_way;
		else
			rd_way = victim;
	end

	always_comb begin
		ctrl = '0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		mem_resp = 1'b0;

		case (state)
			st_idle: begin
				if (write && hit) begin
					ctrl.ld_way = hit_mask;
					ctrl.ld_dirty = hit_mask;
					ctrl.dirty_in = 1'b1;
					ctrl.ld_lru = 1'b1;
				end
			end

			st_read: begin
				if (!victim_dirty) begin
					pmem_read = 1'b1;
					ctrl.fill_sel = 1'b1;
					if (pmem_resp) begin
						ctrl.ld_way = victim_mask; // Line fill
						ctrl.ld_tag = victim_mask;
						ctrl.ld_valid = victim_mask;
					end
				end
			end

			st_write_mem: begin
				pmem_write = 1'b1;
				ctrl.wb_sel = 1'b1;
				if (pmem_resp) begin
					ctrl.ld_dirty = victim_mask; // Victim now clean
					ctrl.dirty_in = 1'b0;
				end
			end

			st_resp: begin
				mem_resp = 1'b1;
				ctrl.ld_lru = 1'b1;
			end

			default: ;
		endcase
	end

	always_comb begin
		state_next = state;

		case (state)
			st_idle: begin
				if ((read || write) && !hit)
					state_next = st_read;
				else if ((read || write) && hit)
					state_next = st_resp;
			end

			st_read: begin
				if (victim_dirty)
					state_next = st_write_mem;
				else if (pmem_resp)
					state_next = read ? st_resp : st_idle; // Write retries as a hit
			end

			st_write_mem: begin
				if (pmem_resp)
					state_next = st_read;
			end

			st_resp: begin
				state_next = st_idle;
			end

			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= st_idle;
		else
			state <= state_next;
	end

endmodule : l2_cache_control

//--- design/l2_cache_params.svh
`ifndef L2_CACHE_PARAMS_SVH
`define L2_CACHE_PARAMS_SVH

// Cache geometry with 4 ways fixed by the PLRU tree
`define L2_SETS 8
`define L2_INDEX_BITS 3
`define L2_TAG_BITS 8
`define L2_LINE_BITS 64

// Line address is tag above index
`define L2_ADDR_BITS (`L2_TAG_BITS + `L2_INDEX_BITS)

`endif

//--- design/l2_cache_pkg.sv
`include "l2_cache_params.svh"

package l2_cache_pkg;

	typedef logic [`L2_ADDR_BITS-1:0] l2_addr_t;
	typedef logic [`L2_INDEX_BITS-1:0] l2_index_t;
	typedef logic [`L2_TAG_BITS-1:0] l2_tag_t;
	typedef logic [`L2_LINE_BITS-1:0] l2_line_t;

	typedef logic [1:0] way_t;
	typedef logic [3:0] way_mask_t; // One bit per way
	typedef logic [2:0] plru_t; // [2] half, [1] in 0/1, [0] in 2/3

	typedef struct packed {
		logic read;
		logic write;
		l2_addr_t addr;
		l2_line_t wdata;
	} l2_req_t;

	typedef struct packed {
		way_mask_t ld_way; // Data array write
		way_mask_t ld_tag;
		way_mask_t ld_valid;
		way_mask_t ld_dirty;
		logic dirty_in;
		logic ld_lru;
		logic fill_sel; // Data from memory
		logic wb_sel; // Victim tag as memory address
	} l2_ctrl_t;

	typedef enum logic [1:0] {st_idle, st_read, st_write_mem, st_resp} l2_state_e;

endpackage : l2_cache_pkg

//--- design/l2_data_array.sv
`include "l2_cache_params.svh"

module l2_data_array (
	input logic clk,
	input logic rst,
	input l2_cache_pkg::l2_index_t index,
	input l2_cache_pkg::way_mask_t ld_way,
	input l2_cache_pkg::l2_line_t wdata,
	input l2_cache_pkg::way_t rd_way,
	output l2_cache_pkg::l2_line_t rdata
);
	import l2_cache_pkg::*;

	l2_line_t lines_q [4][`L2_SETS];

	// Combinational read of the selected way
	assign rdata = lines_q[rd_way][index];

	// Writes are held off while in reset
	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int w = 0; w < 4; w++) begin
				if (ld_way[w])
					lines_q[w][index] <= wdata;
			end
		end
	end

endmodule : l2_data_array

//--- design/l2_plru.sv
`include "l2_cache_params.svh"

module l2_plru (
	input logic clk,
	input logic rst,
	input l2_cache_pkg::l2_index_t index,
	input logic ld_lru,
	input l2_cache_pkg::way_t access_way,
	output l2_cache_pkg::way_t victim
);
	import l2_cache_pkg::*;

	plru_t tree_q [`L2_SETS];
	plru_t cur;
	plru_t upd;

	assign cur = tree_q[index];

	// Follow the tree to the least recently used leaf
	always_comb begin
		if (cur[2])
			victim = {1'b1, cur[0]};
		else
			victim = {1'b0, cur[1]};
	end

	// Point the accessed way's path away from it
	always_comb begin
		upd = cur;
		upd[2] = ~access_way[1];
		if (access_way[1])
			upd[0] = ~access_way[0];
		else
			upd[1] = ~access_way[0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `L2_SETS; s++)
				tree_q[s] <= '0;
		end else if (ld_lru) begin
			tree_q[index] <= upd;
		end
	end

endmodule : l2_plru

//--- design/l2_way_meta.sv
`include "l2_cache_params.svh"

module l2_way_meta (
	input logic clk,
	input logic rst,
	input l2_cache_pkg::l2_index_t index,
	input l2_cache_pkg::l2_tag_t tag,
	input l2_cache_pkg::l2_ctrl_t ctrl,
	output logic hit,
	output l2_cache_pkg::way_t hit_way,
	output l2_cache_pkg::way_mask_t dirty,
	output l2_cache_pkg::l2_tag_t way_tags [4]
);
	import l2_cache_pkg::*;

	way_mask_t valid_q [`L2_SETS]; // Bit per way, word per set
	way_mask_t dirty_q [`L2_SETS];
	l2_tag_t tag_q [4][`L2_SETS];

	way_mask_t match;

	// Tag compare across the indexed set
	always_comb begin
		for (int w = 0; w < 4; w++) begin
			way_tags[w] = tag_q[w][index];
			match[w] = valid_q[index][w] && (tag_q[w][index] == tag);
		end
	end

	assign hit = |match;
	assign dirty = dirty_q[index];

	// Lowest matching way wins
	always_comb begin
		hit_way = '0;
		for (int w = 3; w >= 0; w--) begin
			if (match[w])
				hit_way = way_t'(w);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `L2_SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
		end else begin
			for (int w = 0; w < 4; w++) begin
				if (ctrl.ld_valid[w])
					valid_q[index][w] <= 1'b1; // Only set on a fill
				if (ctrl.ld_dirty[w])
					dirty_q[index][w] <= ctrl.dirty_in;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < 4; w++) begin
			if (ctrl.ld_tag[w])
				tag_q[w][index] <= tag;
		end
	end

endmodule : l2_way_meta

//--- flist.f
+incdir+design
design/l2_cache_pkg.sv
design/l2_plru.sv
design/l2_way_meta.sv
design/l2_data_array.sv
design/l2_cache_control.sv
design/l2_cache.sv
verification/l2_cache_assert.sv
verification/l2_cache_checker.sv
verification/l2_cache_tb.sv

//--- verification/l2_cache_assert.sv
module l2_cache_assert (
	input logic clk,
	input logic rst,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp,
	input logic mem_resp,
	input l2_cache_pkg::l2_state_e state
);
	timeunit 1ns;
	timeprecision 1ps;
	import l2_cache_pkg::*;

	int failures = 0;

	read_held: assert property (@(posedge clk) disable iff (rst)
		pmem_read && !pmem_resp |=> pmem_read)
	else begin
		$error("memory read dropped before its response");
		failures++;
	end

	write_held: assert property (@(posedge clk) disable iff (rst)
		pmem_write && !pmem_resp |=> pmem_write)
	else begin
		$error("memory write dropped before its response");
		failures++;
	end

	one_mem_cmd: assert property (@(posedge clk) disable iff (rst)
		!(pmem_read && pmem_write))
	else begin
		$error("memory read and write requested together");
		failures++;
	end

	resp_pulse: assert property (@(posedge clk) disable iff (rst)
		mem_resp |=> !mem_resp)
	else begin
		$error("upper-level response longer than one cycle");
		failures++;
	end

	// A write-back only ever hands over to the fill
	legal_transition: assert property (@(posedge clk) disable iff (rst)
		$past(state) == st_write_mem |-> state inside {st_write_mem, st_read})
	else begin
		$error("controller left the write-back state for a state other than read");
		failures++;
	end

endmodule : l2_cache_assert

//--- verification/l2_cache_checker.sv
`include "l2_cache_params.svh"

module l2_cache_checker (
	input logic clk,
	input logic rst,
	input l2_cache_pkg::l2_req_t req,
	input l2_cache_pkg::l2_line_t mem_rdata,
	input logic mem_resp,
	input logic pmem_read,
	input logic pmem_write,
	input l2_cache_pkg::l2_addr_t pmem_address,
	input l2_cache_pkg::l2_line_t pmem_wdata,
	input logic pmem_resp,
	input int test_no,
	output int error_count
);
	timeunit 1ns;
	timeprecision 1ps;
	import l2_cache_pkg::*;

	// Model cache and model memory
	logic m_valid [`L2_SETS][4];
	logic m_dirty [`L2_SETS][4];
	l2_tag_t m_tag [`L2_SETS][4];
	l2_line_t m_data [`L2_SETS][4];
	plru_t m_tree [`L2_SETS];
	l2_line_t m_mem [2 ** `L2_ADDR_BITS];

	logic busy;
	logic exp_hit;
	logic exp_wb;
	logic saw_wb;
	logic saw_fill;
	l2_addr_t exp_wb_addr;
	l2_line_t exp_wb_data;
	l2_line_t exp_rdata;
	int cycles;

	function automatic l2_line_t init_line(l2_addr_t a);
		return {32'h5a00_0000 | 32'(a), 32'(a) * 32'd2654435761};
	endfunction

	function automatic string test_label(int n);
		case (n)
			1: return "reset_miss";
			2: return "read_hit";
			3: return "write_hit";
			4: return "write_miss_evict";
			5: return "plru_evict";
			6: return "random_mix";
			default: return "idle";
		endcase
	endfunction

	// Applies one access to the model and returns what the cache must do
	function automatic void ref_access(input logic wr, input l2_addr_t addr,
		input l2_line_t wdata, output logic hit, output logic wb,
		output l2_addr_t wb_addr, output l2_line_t wb_data, output l2_line_t rdata);
		l2_index_t idx;
		l2_tag_t tg;
		int way;
		idx = addr[`L2_INDEX_BITS-1:0];
		tg = addr[`L2_ADDR_BITS-1:`L2_INDEX_BITS];
		hit = 1'b0;
		wb = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		way = 0;
		for (int w = 3; w >= 0; w--) begin
			if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
				hit = 1'b1;
				way = w;
			end
		end
		if (!hit) begin
			way = m_tree[idx][2] ? {1'b1, m_tree[idx][0]} : {1'b0, m_tree[idx][1]};
			if (m_valid[idx][way] && m_dirty[idx][way]) begin
				wb = 1'b1;
				wb_addr = {m_tag[idx][way], idx};
				wb_data = m_data[idx][way];
				m_mem[wb_addr] = wb_data;
			end
			m_data[idx][way] = m_mem[addr];
			m_tag[idx][way] = tg;
			m_valid[idx][way] = 1'b1;
			m_dirty[idx][way] = 1'b0;
		end
		if (wr) begin
			m_data[idx][way] = wdata;
			m_dirty[idx][way] = 1'b1;
		end
		m_tree[idx][2] = (way < 2); // Point away from the way just used
		if (way >= 2)
			m_tree[idx][0] = (way == 2);
		else
			m_tree[idx][1] = (way == 0);
		rdata = m_data[idx][way];
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		$display("mismatch %s %s expected %h actual %h", test_label(test_no), what, exp, act);
		error_count++;
	endtask

	task automatic report_error(input string msg);
		$display("error in %s: %s", test_label(test_no), msg);
		error_count++;
	endtask

	initial begin
		error_count = 0;
		busy = 1'b0;
		for (int a = 0; a < 2 ** `L2_ADDR_BITS; a++)
			m_mem[a] = init_line(l2_addr_t'(a));
	end

	always @(negedge clk) begin
		if (rst) begin
			busy = 1'b0;
			for (int s = 0; s < `L2_SETS; s++) begin
				m_tree[s] = '0;
				for (int w = 0; w < 4; w++) begin
					m_valid[s][w] = 1'b0;
					m_dirty[s][w] = 1'b0;
				end
			end
		end else begin
			if (!busy && (req.read || req.write)) begin
				ref_access(req.write, req.addr, req.wdata, exp_hit, exp_wb, exp_wb_addr,
					exp_wb_data, exp_rdata);
				busy = 1'b1;
				cycles = 0;
				saw_wb = 1'b0;
				saw_fill = 1'b0;
			end else if (busy) begin
				cycles++;
			end

			if (pmem_write && pmem_resp) begin
				saw_wb = 1'b1;
				if (!busy || !exp_wb) begin
					report_error("write-back that the model does not expect");
				end else begin
					if (pmem_address !== exp_wb_addr)
						report_mismatch("write-back address", exp_wb_addr, pmem_address);
					if (pmem_wdata !== exp_wb_data)
						report_mismatch("write-back data", exp_wb_data, pmem_wdata);
				end
			end

			if (pmem_read && pmem_resp) begin
				saw_fill = 1'b1;
				if (!busy || exp_hit)
					report_error("memory read on an access that should hit");
				else if (pmem_address !== req.addr)
					report_mismatch("fill address", req.addr, pmem_address);
			end

			if (mem_resp) begin
				if (!busy) begin
					report_error("response with no request pending");
				end else begin
					if (mem_rdata !== exp_rdata)
						report_mismatch("response data", exp_rdata, mem_rdata);
					if (exp_hit && cycles != 1)
						report_mismatch("hit latency", 1, cycles);
					if (!exp_hit && !saw_fill)
						report_error("miss completed without reading memory");
					if (exp_wb && !saw_wb)
						report_error("dirty victim was never written back");
					busy = 1'b0;
				end
			end
		end
	end

endmodule : l2_cache_checker

//--- verification/l2_cache_tb.sv
`include "l2_cache_params.svh"

module l2_cache_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import l2_cache_pkg::*;

	localparam int MEM_LINES = 2 ** `L2_ADDR_BITS;
	localparam int RESP_TIMEOUT = 200; // Cycles

	logic clk;
	logic rst;
	l2_req_t req;
	l2_line_t mem_rdata;
	logic mem_resp;
	logic pmem_read;
	logic pmem_write;
	l2_addr_t pmem_address;
	l2_line_t pmem_wdata;
	l2_line_t pmem_rdata;
	logic pmem_resp;

	l2_line_t mem [MEM_LINES];
	logic mem_active;
	int mem_wait;
	int seed;
	int test_no;
	int tb_errors;
	int checker_errors;
	int assert_errors;
	logic abort;

	l2_cache dut_i (
		.clk(clk), .rst(rst), .req(req), .mem_rdata(mem_rdata), .mem_resp(mem_resp),
		.pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
	);

	l2_cache_checker checker_i (
		.clk(clk), .rst(rst), .req(req), .mem_rdata(mem_rdata), .mem_resp(mem_resp),
		.pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata), .pmem_resp(pmem_resp), .test_no(test_no),
		.error_count(checker_errors)
	);

	bind l2_cache_control l2_cache_assert assert_i (
		.clk(clk), .rst(rst), .pmem_read(pmem_read), .pmem_write(pmem_write),
		.pmem_resp(pmem_resp), .mem_resp(mem_resp), .state(state)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic l2_line_t mem_pattern(l2_addr_t a);
		return {32'h5a00_0000 | 32'(a), 32'(a) * 32'd2654435761};
	endfunction

	function automatic int rand_below(int n);
		return {$random(seed)} % n;
	endfunction

	function automatic l2_addr_t line_addr(int tag, int index);
		return {l2_tag_t'(tag), l2_index_t'(index)};
	endfunction

	// Physical memory answering each request after 1 to 6 cycles
	always @(posedge clk) begin
		if (rst) begin
			pmem_resp <= 1'b0;
			mem_active <= 1'b0;
			mem_wait <= 0;
		end else begin
			pmem_resp <= 1'b0;
			if ((pmem_read || pmem_write) && !pmem_resp) begin
				if (!mem_active) begin
					mem_active <= 1'b1;
					mem_wait <= rand_below(6);
				end else if (mem_wait > 0) begin
					mem_wait <= mem_wait - 1;
				end else begin
					mem_active <= 1'b0;
					pmem_resp <= 1'b1;
					if (pmem_write)
						mem[pmem_address] <= pmem_wdata;
					else
						pmem_rdata <= mem[pmem_address];
				end
			end
		end
	end

	task automatic do_access(input logic wr, input l2_addr_t addr, input l2_line_t wdata);
		int waited;
		if (abort)
			return;
		@(posedge clk);
		req.read <= !wr;
		req.write <= wr;
		req.addr <= addr;
		req.wdata <= wdata;
		waited = 0;
		@(negedge clk);
		while (!mem_resp && waited < RESP_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!mem_resp) begin
			$display("error: no response for line %h within %0d cycles", addr, RESP_TIMEOUT);
			tb_errors++;
			abort = 1'b1;
		end
		@(posedge clk);
		req.read <= 1'b0;
		req.write <= 1'b0;
	endtask

	initial begin
		seed = 62586;
		tb_errors = 0;
		abort = 1'b0;
		test_no = 0;
		rst = 1'b1;
		req = '0;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		for (int a = 0; a < MEM_LINES; a++)
			mem[a] = mem_pattern(l2_addr_t'(a));
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		repeat (3) begin
			@(negedge clk);
			if (pmem_read || pmem_write || mem_resp) begin
				$display("error: cache outputs active after reset with no request");
				tb_errors++;
			end
		end

		test_no = 1;
		do_access(1'b0, line_addr(8'h21, 1), '0);
		test_no = 2;
		do_access(1'b0, line_addr(8'h21, 1), '0);
		test_no = 3;
		do_access(1'b1, line_addr(8'h21, 1), 64'hfeed_cafe_0123_4567);
		do_access(1'b0, line_addr(8'h21, 1), '0);

		test_no = 4; // Write miss and then four more tags push it out
		do_access(1'b1, line_addr(8'h40, 2), 64'h0bad_f00d_7777_1111);
		for (int t = 1; t <= 4; t++)
			do_access(1'b0, line_addr(8'h40 + t, 2), '0);

		test_no = 5;
		for (int t = 0; t <= 4; t++)
			do_access(1'b0, line_addr(8'h50 + t, 3), '0);
		for (int t = 1; t <= 3; t++)
			do_access(1'b0, line_addr(8'h50 + t, 3), '0);
		do_access(1'b0, line_addr(8'h50, 3), '0);

		test_no = 6;
		repeat (400) begin
			do_access(rand_below(2) == 1, line_addr(8'h40 + rand_below(6), 1 + rand_below(3)),
				{$random(seed), $random(seed)});
		end

		test_no = 0;
		repeat (4) @(posedge clk);
		assert_errors = dut_i.control_i.assert_i.failures;
		$display("errors: checker %0d, assertions %0d, testbench %0d",
			checker_errors, assert_errors, tb_errors);
		if (checker_errors == 0 && assert_errors == 0 && tb_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule : l2_cache_tb
